//--- filelist.f
+incdir+hw
hw/selftrig_fsm_pkg.sv
hw/selftrig_count_pkg.sv
hw/buffer_ctrl_if.sv
hw/buffer_swap_control.sv
hw/channel_trigger_receiver.sv
hw/overflow_combiner.sv
hw/selftrigger_top.sv
tests/tb_selftrigger.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       ?= tb_selftrigger
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- tests/tb_selftrigger.sv
/* self-trigger bookkeeping testbench
   directed and random trigger tests checked every cycle against a channel model */
`timescale 1ns/100ps
`default_nettype none

`include "selftrig_params.svh"

module tb_selftrigger import selftrig_fsm_pkg::*, selftrig_count_pkg::*;;

  localparam int NCH = `SELFTRIG_NUM_CHAN;
  // well over ten times the length of all tests together
  localparam int TIMEOUT_CYCLES = 4000;

  logic                     clk;
  logic                     reset;
  logic        [NCH-1:0]    trigger;
  logic        [NCH-1:0]    chan_en;
  logic                     swap_req;
  logic                     reset_trig_num;
  burst_cnt_t               burst_count;
  burst_cnt_t               thres_ddr3_overflow;
  buf_sel_t                 active_buf;
  trig_num_t   [NCH-1:0]    trig_num;
  trig_cnt_t   [NCH-1:0]    selftriggers_lo;
  trig_cnt_t   [NCH-1:0]    selftriggers_hi;
  burst_cnt_t  [NCH-1:0]    stored_bursts_lo;
  burst_cnt_t  [NCH-1:0]    stored_bursts_hi;
  chan_state_t [NCH-1:0]    state;
  logic                     ddr3_almost_full;
  logic                     overflow_seen;
  int                       cycles = 0;

  // channel model, half index 0 is lo and 1 is hi
  trig_num_t  m_num [NCH];
  trig_cnt_t  m_cnt [2][NCH];
  burst_cnt_t m_bur [2][NCH];
  logic       m_hi [NCH];
  logic       m_active;
  // registered strobes and configuration as seen by the channels
  logic       m_changed;
  logic       m_num_clear;
  logic       m_full;
  logic       m_seen;
  burst_cnt_t m_bsize;
  burst_cnt_t m_thres;

  selftrigger_top i_selftrigger_top (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // hard stop if the run never reaches its end
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("error: timeout, run went past %0d cycles", TIMEOUT_CYCLES);
      $display("test failed");
      $fatal(1, "simulation stopped by timeout");
    end
  end

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      $display("error: time %0t signal %s actual 0x%0h expected 0x%0h",
               $time, name, actual, expected);
      $display("test failed");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  task automatic compare_model();
    check_value("active_buf", active_buf, m_active);
    check_value("ddr3_almost_full", ddr3_almost_full, m_full);
    check_value("overflow_seen", overflow_seen, m_seen);
    for (int ch = 0; ch < NCH; ch++) begin
      check_value($sformatf("trig_num[%0d]", ch), trig_num[ch], m_num[ch]);
      check_value($sformatf("selftriggers_lo[%0d]", ch), selftriggers_lo[ch], m_cnt[0][ch]);
      check_value($sformatf("selftriggers_hi[%0d]", ch), selftriggers_hi[ch], m_cnt[1][ch]);
      check_value($sformatf("stored_bursts_lo[%0d]", ch), stored_bursts_lo[ch], m_bur[0][ch]);
      check_value($sformatf("stored_bursts_hi[%0d]", ch), stored_bursts_hi[ch], m_bur[1][ch]);
      check_value($sformatf("state[%0d]", ch), state[ch],
                  m_hi[ch] ? STATE_TRIG_HI : STATE_IDLE);
    end
  endtask

  // advance the model over one edge, then the DUT, then compare
  task automatic tick();
    logic any_full;
    logic edge_ok;
    any_full = 1'b0;
    for (int ch = 0; ch < NCH; ch++) begin
      // warning looks at the totals from before this edge
      if (chan_en[ch] && m_bur[m_active][ch] > m_thres) begin
        any_full = 1'b1;
      end
      edge_ok = !m_hi[ch] && trigger[ch] && chan_en[ch];
      if (m_num_clear) begin
        m_num[ch] = '0;
      end else if (edge_ok) begin
        m_num[ch] += 1'b1;
      end
      // clear of the new half beats a trigger
      if (m_changed) begin
        m_cnt[m_active][ch] = '0;
        m_bur[m_active][ch] = '0;
      end else if (edge_ok) begin
        m_cnt[m_active][ch] += 1'b1;
        m_bur[m_active][ch] += m_bsize;
      end
      m_hi[ch] = m_hi[ch] ? trigger[ch] : (trigger[ch] && chan_en[ch]);
    end
    m_full = any_full;
    m_seen = m_changed ? 1'b0 : (m_seen | any_full);
    m_changed = swap_req;
    m_num_clear = reset_trig_num;
    if (swap_req) begin
      m_active = !m_active;
    end
    m_bsize = burst_count + 1'b1;
    m_thres = thres_ddr3_overflow;
    @(posedge clk);
    #1;
    compare_model();
  endtask

  task automatic model_reset();
    for (int ch = 0; ch < NCH; ch++) begin
      m_num[ch] = '0;
      m_hi[ch] = 1'b0;
      for (int h = 0; h < 2; h++) begin
        m_cnt[h][ch] = '0;
        m_bur[h][ch] = '0;
      end
    end
    m_active = 1'b0;
    m_changed = 1'b0;
    m_num_clear = 1'b0;
    m_full = 1'b0;
    m_seen = 1'b0;
    m_bsize = burst_count + 1'b1;
    m_thres = thres_ddr3_overflow;
  endtask

  task automatic reset_values();
    compare_model();
    check_value("active_buf", active_buf, buf_lo);
    check_value("ddr3_almost_full", ddr3_almost_full, 1'b0);
  endtask

  // channel 0 disabled, every other channel sees one held trigger
  task automatic held_trigger_once();
    chan_en = 5'b11110;
    trigger = '1;
    repeat (4) tick();
    trigger = '0;
    repeat (2) tick();
    check_value("trig_num[1]", trig_num[1], 1);
    check_value("selftriggers_lo[1]", selftriggers_lo[1], 1);
    check_value("stored_bursts_lo[1]", stored_bursts_lo[1], burst_count + 1);
    check_value("trig_num[0]", trig_num[0], 0);
  endtask

  task automatic swap_halves();
    swap_req = 1'b1;
    tick();
    swap_req = 1'b0;
    check_value("active_buf", active_buf, buf_hi);
    tick();
    trigger[2] = 1'b1;
    tick();
    trigger[2] = 1'b0;
    tick();
    check_value("selftriggers_hi[2]", selftriggers_hi[2], 1);
    check_value("selftriggers_lo[2]", selftriggers_lo[2], 1);
    // back to lo, cleared one edge after the strobe
    swap_req = 1'b1;
    tick();
    swap_req = 1'b0;
    check_value("selftriggers_lo[2]", selftriggers_lo[2], 1);
    tick();
    check_value("selftriggers_lo[2]", selftriggers_lo[2], 0);
    check_value("selftriggers_hi[2]", selftriggers_hi[2], 1);
  endtask

  task automatic clear_trig_numbers();
    reset_trig_num = 1'b1;
    tick();
    reset_trig_num = 1'b0;
    tick();
    for (int ch = 0; ch < NCH; ch++) begin
      check_value($sformatf("trig_num[%0d]", ch), trig_num[ch], 0);
    end
    check_value("selftriggers_hi[2]", selftriggers_hi[2], 1);
  endtask

  task automatic random_trigger_bursts();
    for (int b = 0; b < 6; b++) begin
      chan_en = NCH'($urandom);
      burst_count = burst_cnt_t'($urandom_range(15, 0));
      repeat (40) begin
        trigger = NCH'($urandom);
        tick();
      end
      trigger = '0;
      tick();
      swap_req = 1'b1;
      tick();
      swap_req = 1'b0;
      tick();
    end
  endtask

  // channel 3 alone, 4 bursts per trigger against a threshold of 5
  task automatic almost_full_warning();
    chan_en = 5'b01000;
    swap_req = 1'b1;
    tick();
    swap_req = 1'b0;
    tick();
    burst_count = 3;
    thres_ddr3_overflow = 5;
    tick();
    trigger[3] = 1'b1;
    tick();
    trigger[3] = 1'b0;
    tick();
    check_value("ddr3_almost_full", ddr3_almost_full, 1'b0);
    trigger[3] = 1'b1;
    tick();
    check_value("stored_bursts_act[3]",
                m_active ? stored_bursts_hi[3] : stored_bursts_lo[3], 8);
    check_value("ddr3_almost_full", ddr3_almost_full, 1'b0);
    trigger[3] = 1'b0;
    tick();
    check_value("ddr3_almost_full", ddr3_almost_full, 1'b1);
    check_value("overflow_seen", overflow_seen, 1'b1);
    chan_en = '0;
    tick();
    check_value("ddr3_almost_full", ddr3_almost_full, 1'b0);
    check_value("overflow_seen", overflow_seen, 1'b1);
    swap_req = 1'b1;
    tick();
    swap_req = 1'b0;
    check_value("overflow_seen", overflow_seen, 1'b1);
    tick();
    check_value("overflow_seen", overflow_seen, 1'b0);
  endtask

  initial begin
    void'($urandom(52));
    reset = 1'b1;
    trigger = '0;
    chan_en = '0;
    swap_req = 1'b0;
    reset_trig_num = 1'b0;
    burst_count = 7;
    thres_ddr3_overflow = '1;
    repeat (4) @(posedge clk);
    #1;
    reset = 1'b0;
    model_reset();
    reset_values();
    held_trigger_once();
    swap_halves();
    clear_trig_numbers();
    random_trigger_bursts();
    almost_full_warning();
    $display("test passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- hw/selftrigger_top.sv
/* self-trigger bookkeeping top
   buffer swap control, one receiver per channel and the overflow combiner */
`timescale 1ns/100ps
`default_nettype none

`include "selftrig_params.svh"

module selftrigger_top import selftrig_fsm_pkg::*, selftrig_count_pkg::*; (
  input  logic                                    clk,
  input  logic                                    reset,
  input  logic        [`SELFTRIG_NUM_CHAN-1:0]    trigger,
  input  logic        [`SELFTRIG_NUM_CHAN-1:0]    chan_en,
  input  logic                                    swap_req,
  input  logic                                    reset_trig_num,
  input  burst_cnt_t                              burst_count,
  input  burst_cnt_t                              thres_ddr3_overflow,
  output buf_sel_t                                active_buf,
  output trig_num_t   [`SELFTRIG_NUM_CHAN-1:0]    trig_num,
  output trig_cnt_t   [`SELFTRIG_NUM_CHAN-1:0]    selftriggers_lo,
  output trig_cnt_t   [`SELFTRIG_NUM_CHAN-1:0]    selftriggers_hi,
  output burst_cnt_t  [`SELFTRIG_NUM_CHAN-1:0]    stored_bursts_lo,
  output burst_cnt_t  [`SELFTRIG_NUM_CHAN-1:0]    stored_bursts_hi,
  output chan_state_t [`SELFTRIG_NUM_CHAN-1:0]    state,
  output logic                                    ddr3_almost_full,
  output logic                                    overflow_seen
);

  logic [`SELFTRIG_NUM_CHAN-1:0] chan_almost_full;

  // shared by the control module and all channels
  buffer_ctrl_if ctrl_bus ();

  buffer_swap_control i_buffer_swap_control (
    .clk                 (clk),
    .reset               (reset),
    .swap_req            (swap_req),
    .reset_trig_num      (reset_trig_num),
    .burst_count         (burst_count),
    .thres_ddr3_overflow (thres_ddr3_overflow),
    .bus                 (ctrl_bus)
  );

  for (genvar i = 0; i < `SELFTRIG_NUM_CHAN; i++) begin : g_chan
    buf_occupancy_t occupancy;

    channel_trigger_receiver i_channel_trigger_receiver (
      .clk              (clk),
      .reset            (reset),
      .trigger          (trigger[i]),
      .chan_en          (chan_en[i]),
      .bus              (ctrl_bus),
      .trig_num         (trig_num[i]),
      .occupancy        (occupancy),
      .state            (state[i]),
      .chan_almost_full (chan_almost_full[i])
    );

    // record split onto the flat per-channel outputs
    assign selftriggers_lo[i]  = occupancy.selftriggers_lo;
    assign selftriggers_hi[i]  = occupancy.selftriggers_hi;
    assign stored_bursts_lo[i] = occupancy.stored_bursts_lo;
    assign stored_bursts_hi[i] = occupancy.stored_bursts_hi;
  end

  overflow_combiner i_overflow_combiner (
    .clk              (clk),
    .reset            (reset),
    .chan_almost_full (chan_almost_full),
    .buf_changed      (ctrl_bus.buf_changed),
    .ddr3_almost_full (ddr3_almost_full),
    .overflow_seen    (overflow_seen)
  );

  assign active_buf = ctrl_bus.active_buf;

endmodule

`default_nettype wire

//--- hw/overflow_combiner.sv
/* DDR3 overflow combiner
   registered OR of channel warnings plus a sticky flag cleared on swap */
`timescale 1ns/100ps
`default_nettype none

`include "selftrig_params.svh"

module overflow_combiner (
  input  logic                          clk,
  input  logic                          reset,
  // one warning bit per channel
  input  logic [`SELFTRIG_NUM_CHAN-1:0] chan_almost_full,
  // halves were just swapped
  input  logic                          buf_changed,
  output logic                          ddr3_almost_full,
  output logic                          overflow_seen
);

  logic any_full;

  assign any_full = |chan_almost_full;

  // follows the channels one cycle later
  always_ff @(posedge clk) begin
    if (reset) begin
      ddr3_almost_full <= 1'b0;
    end else begin
      ddr3_almost_full <= any_full;
    end
  end

  // held from the first warning, a swap starts over
  always_ff @(posedge clk) begin
    if (reset || buf_changed) begin
      overflow_seen <= 1'b0;
    end else if (any_full) begin
      overflow_seen <= 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- hw/channel_trigger_receiver.sv
/* channel self-trigger receiver
   counts trigger edges per buffer half and flags an almost-full DDR3 half */
`timescale 1ns/100ps
`default_nettype none

`include "selftrig_params.svh"

module channel_trigger_receiver import selftrig_fsm_pkg::*, selftrig_count_pkg::*; (
  input  logic           clk,
  input  logic           reset,
  // self-trigger level from the channel
  input  logic           trigger,
  // channel takes part in acquisition
  input  logic           chan_en,
  buffer_ctrl_if.chan    bus,
  // global trigger number of this channel
  output trig_num_t      trig_num,
  // trigger counts and burst totals for both halves
  output buf_occupancy_t occupancy,
  output chan_state_t    state,
  // active half is past the threshold
  output logic           chan_almost_full
);

  chan_state_t next_state;
  logic        trig_edge;
  burst_cnt_t  active_bursts;

  // a new trigger is only taken from idle
  assign trig_edge = state.idle & trigger & chan_en;

  // held trigger parks in trig_hi until it drops
  always_comb begin
    next_state = state;
    case (1'b1)
      state.idle: begin
        if (trigger & chan_en) begin
          next_state = STATE_TRIG_HI;
        end
      end
      state.trig_hi: begin
        if (!trigger) begin
          next_state = STATE_IDLE;
        end
      end
      default: next_state = STATE_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= STATE_IDLE;
    end else begin
      state <= next_state;
    end
  end

  // trigger number ignores buffer swaps
  always_ff @(posedge clk) begin
    if (reset || bus.trig_num_clear) begin
      trig_num <= `SELFTRIG_TRIG_NUM_RST;
    end else if (trig_edge) begin
      trig_num <= trig_num + 1'b1;
    end
  end

  // clear of the new active half wins over a trigger in the same cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      occupancy.selftriggers_lo  <= `SELFTRIG_TRIG_CNT_RST;
      occupancy.selftriggers_hi  <= `SELFTRIG_TRIG_CNT_RST;
      occupancy.stored_bursts_lo <= `SELFTRIG_BURST_RST;
      occupancy.stored_bursts_hi <= `SELFTRIG_BURST_RST;
    end else if (bus.buf_changed) begin
      // other half keeps its totals for readout
      if (bus.active_buf == buf_hi) begin
        occupancy.selftriggers_hi  <= `SELFTRIG_TRIG_CNT_RST;
        occupancy.stored_bursts_hi <= `SELFTRIG_BURST_RST;
      end else begin
        occupancy.selftriggers_lo  <= `SELFTRIG_TRIG_CNT_RST;
        occupancy.stored_bursts_lo <= `SELFTRIG_BURST_RST;
      end
    end else if (trig_edge) begin
      // one burst block per edge, matching the trigger count
      if (bus.active_buf == buf_hi) begin
        occupancy.selftriggers_hi  <= occupancy.selftriggers_hi + 1'b1;
        occupancy.stored_bursts_hi <= occupancy.stored_bursts_hi + bus.burst_size;
      end else begin
        occupancy.selftriggers_lo  <= occupancy.selftriggers_lo + 1'b1;
        occupancy.stored_bursts_lo <= occupancy.stored_bursts_lo + bus.burst_size;
      end
    end
  end

  // only the half being written can fill up
  assign active_bursts = (bus.active_buf == buf_hi) ? occupancy.stored_bursts_hi
                                                    : occupancy.stored_bursts_lo;
  assign chan_almost_full = chan_en & (active_bursts > bus.overflow_thres);

endmodule

`default_nettype wire

//--- hw/buffer_swap_control.sv
/* buffer swap control
   owns the active DDR3 half and issues clear and trigger-number reset strobes */
`timescale 1ns/100ps
`default_nettype none

module buffer_swap_control import selftrig_fsm_pkg::*, selftrig_count_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  // toggle the active half
  input  logic        swap_req,
  // zero the trigger numbers of all channels
  input  logic        reset_trig_num,
  // configured bursts per trigger, minus one
  input  burst_cnt_t  burst_count,
  // stored-burst level that raises almost full
  input  burst_cnt_t  thres_ddr3_overflow,
  buffer_ctrl_if.ctrl bus
);

  // active half flips on every request
  always_ff @(posedge clk) begin
    if (reset) begin
      bus.active_buf <= buf_lo;
    end else if (swap_req) begin
      bus.active_buf <= (bus.active_buf == buf_lo) ? buf_hi : buf_lo;
    end
  end

  // strobes follow their request by one edge
  // so buf_changed lines up with the new active_buf
  always_ff @(posedge clk) begin
    if (reset) begin
      bus.buf_changed    <= 1'b0;
      bus.trig_num_clear <= 1'b0;
    end else begin
      bus.buf_changed    <= swap_req;
      bus.trig_num_clear <= reset_trig_num;
    end
  end

  // configuration registered once here
  // every channel then adds the same stable value
  always_ff @(posedge clk) begin
    bus.burst_size     <= burst_count + 1'b1;
    bus.overflow_thres <= thres_ddr3_overflow;
  end

endmodule

`default_nettype wire

//--- hw/buffer_ctrl_if.sv
/* buffer control bus
   active half, swap and trigger-number strobes, burst size and threshold */
`timescale 1ns/100ps
`default_nettype none

interface buffer_ctrl_if import selftrig_fsm_pkg::*, selftrig_count_pkg::*;;

  // half currently collecting triggers
  buf_sel_t   active_buf;
  // single-cycle pulse right after a swap
  logic       buf_changed;
  // single-cycle pulse zeroing all trigger numbers
  logic       trig_num_clear;
  // bursts added per trigger, already includes the +1
  burst_cnt_t burst_size;
  // almost-full compare level
  burst_cnt_t overflow_thres;

  // control side drives everything
  modport ctrl (
    output active_buf,
    output buf_changed,
    output trig_num_clear,
    output burst_size,
    output overflow_thres
  );

  // every channel only listens
  modport chan (
    input active_buf,
    input buf_changed,
    input trig_num_clear,
    input burst_size,
    input overflow_thres
  );

endinterface

`default_nettype wire

//--- hw/selftrig_count_pkg.sv
/* self-trigger counter types
   counter widths as types plus the per-channel buffer occupancy record */
`default_nettype none

`include "selftrig_params.svh"

package selftrig_count_pkg;

  // running trigger number of one channel
  typedef logic [`SELFTRIG_TRIG_NUM_W-1:0] trig_num_t;
  // triggers stored in one buffer half
  typedef logic [`SELFTRIG_TRIG_CNT_W-1:0] trig_cnt_t;
  // burst sizes and stored-burst totals
  typedef logic [`SELFTRIG_BURST_W-1:0] burst_cnt_t;

  // what one channel holds in each half of the DDR3 buffer
  typedef struct packed {
    trig_cnt_t  selftriggers_lo;
    trig_cnt_t  selftriggers_hi;
    burst_cnt_t stored_bursts_lo;
    burst_cnt_t stored_bursts_hi;
  } buf_occupancy_t;

endpackage

`default_nettype wire

//--- hw/selftrig_fsm_pkg.sv
/* self-trigger FSM types
   one-hot channel state and DDR3 buffer half select */
`default_nettype none

package selftrig_fsm_pkg;

  // one-hot channel state, exactly one bit set
  typedef struct packed {
    logic trig_hi;
    logic idle;
  } chan_state_t;

  localparam chan_state_t STATE_IDLE = '{trig_hi: 1'b0, idle: 1'b1};
  localparam chan_state_t STATE_TRIG_HI = '{trig_hi: 1'b1, idle: 1'b0};

  // half of the double-buffered DDR3 being written
  typedef enum logic {
    buf_lo = 1'b0,
    buf_hi = 1'b1
  } buf_sel_t;

endpackage

`default_nettype wire

//--- hw/selftrig_params.svh
/* self-trigger bookkeeping constants
   channel count, counter widths and counter reset values */
`ifndef SELFTRIG_PARAMS_SVH
`define SELFTRIG_PARAMS_SVH

// number of digitizer channels feeding self triggers
`define SELFTRIG_NUM_CHAN 5

// global trigger number per channel
`define SELFTRIG_TRIG_NUM_W 24
// triggers held in one half of the DDR3 buffer
`define SELFTRIG_TRIG_CNT_W 20
// burst counts and stored-burst totals
`define SELFTRIG_BURST_W 23

// counter values after reset or clear
`define SELFTRIG_TRIG_NUM_RST {`SELFTRIG_TRIG_NUM_W{1'b0}}
`define SELFTRIG_TRIG_CNT_RST {`SELFTRIG_TRIG_CNT_W{1'b0}}
`define SELFTRIG_BURST_RST {`SELFTRIG_BURST_W{1'b0}}

`endif
